// File: aluUnit.sv
`include "cpu_macros.svh"

module aluUnit (
    input  cpuPkg::word_t rs1Data,
    input  cpuPkg::word_t rs2Data,
    input  cpuPkg::word_t imm,
    ctrlIf.dp             ctrl,
    output cpuPkg::word_t aluResult,
    output logic          zero
);
    import cpuPkg::*;

    word_t opB;
    logic  lessThan;

    assign opB      = ctrl.aluSrcImm ? imm : rs2Data;  // Immediate or rs2
    assign lessThan = $signed(rs1Data) < $signed(opB);

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluResult = rs1Data + opB;
            aluSub:  aluResult = rs1Data - opB;
            aluAnd:  aluResult = rs1Data & opB;
            aluOr:   aluResult = rs1Data | opB;
            aluXor:  aluResult = rs1Data ^ opB;
            aluSlt:  aluResult = {{(`XLEN-1){1'b0}}, lessThan};
            default: aluResult = rs1Data + opB;
        endcase
    end

    // Branch compare uses the subtract result
    assign zero = (aluResult == '0);

endmodule

// File: controlUnit.sv
module controlUnit (
    input logic          run,
    input cpuPkg::word_t inst,
    ctrlIf.ctrl          ctrl
);
    import cpuPkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       regWriteDec;
    logic       memWriteDec;

    // Maps funct3 plus the SUB bit to an ALU operation
    function automatic aluOp_e decodeAlu(logic [2:0] f3, logic subBit);
        case ({subBit, f3})
            4'b0_000: return aluAdd;
            4'b1_000: return aluSub;
            4'b0_111: return aluAnd;
            4'b0_110: return aluOr;
            4'b0_100: return aluXor;
            4'b0_010: return aluSlt;
            default:  return aluAdd;
        endcase
    endfunction

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];

    always_comb begin
        // Unknown opcodes fall through as a no-op
        regWriteDec    = 1'b0;
        memWriteDec    = 1'b0;
        ctrl.aluSrcImm = 1'b0;
        ctrl.memToReg  = 1'b0;
        ctrl.branchEq  = 1'b0;
        ctrl.branchNe  = 1'b0;
        ctrl.immSel    = immI;
        ctrl.aluOp     = aluAdd;

        case (opcode)
            opReg: begin
                regWriteDec = 1'b1;
                ctrl.aluOp  = decodeAlu(funct3, inst[30]);
            end
            opImm: begin
                regWriteDec    = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = decodeAlu(funct3, 1'b0);  // Bit 30 is immediate here
            end
            opLoad: begin
                regWriteDec    = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memToReg  = 1'b1;
            end
            opStore: begin
                memWriteDec    = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immSel    = immS;
            end
            opBranch: begin
                ctrl.immSel   = immB;
                ctrl.aluOp    = aluSub;               // Equality via zero flag
                ctrl.branchEq = (funct3 == 3'b000);
                ctrl.branchNe = (funct3 == 3'b001);
            end
            default: ;
        endcase
    end

    // Nothing commits while halted
    assign ctrl.regWrite = regWriteDec & run;
    assign ctrl.memWrite = memWriteDec & run;

    noDualWrite: assert final (!(ctrl.memWrite && ctrl.regWrite))
        else $error("memWrite and regWrite both high");

endmodule

// File: cpuPkg.sv
`include "cpu_macros.svh"

package cpuPkg;

    typedef logic [`XLEN-1:0] word_t;   // One data word
    typedef logic [4:0]       regIdx_t; // rs1, rs2 or rd field

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,  // ADD SUB AND OR XOR SLT
        opImm    = 7'b0010011,  // ADDI
        opLoad   = 7'b0000011,  // LW
        opStore  = 7'b0100011,  // SW
        opBranch = 7'b1100011   // BEQ BNE
    } opcode_e;

    // Operations the ALU can perform
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSlt = 3'd5   // Signed compare
    } aluOp_e;

    // Immediate format
    typedef enum logic [1:0] {
        immI = 2'd0,
        immS = 2'd1,
        immB = 2'd2
    } immSel_e;

endpackage

// File: cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data and address width
`define XLEN 32

// Architectural registers including x0
`define REG_COUNT 32

// Memory depths in words
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

// PC value out of reset
`define RESET_PC 32'h0000_0000

`endif

// File: ctrlIf.sv
interface ctrlIf;
    import cpuPkg::*;

    logic    regWrite;
    logic    aluSrcImm;  // Second ALU operand is the immediate
    logic    memWrite;
    logic    memToReg;   // Writeback from data memory
    logic    branchEq;
    logic    branchNe;
    immSel_e immSel;
    aluOp_e  aluOp;

    // Control unit side
    modport ctrl (output regWrite, aluSrcImm, memWrite, memToReg,
                  output branchEq, branchNe, immSel, aluOp);

    // Datapath blocks
    modport dp (input regWrite, aluSrcImm, memWrite, memToReg, immSel, aluOp);

    // Next-PC logic only cares about the branch kind
    modport pc (input branchEq, branchNe);

endinterface

// File: dataMem.sv
`include "cpu_macros.svh"

module dataMem (
    input  logic          CLK,
    input  logic          memWrite,
    input  cpuPkg::word_t addr,
    input  cpuPkg::word_t wData,
    output cpuPkg::word_t rData
);
    import cpuPkg::*;

    localparam int AW = $clog2(`DMEM_DEPTH);

    word_t            mem [0:`DMEM_DEPTH-1];
    logic [AW-1:0]    wordIdx;

    // Byte offset bits ignored for word accesses
    assign wordIdx = addr[AW+1:2];

    always_ff @(posedge CLK) begin
        if (memWrite) begin
            mem[wordIdx] <= wData;
        end
    end

    assign rData = mem[wordIdx];  // Async read for LW

endmodule

// File: immGen.sv
`include "cpu_macros.svh"

module immGen (
    input  cpuPkg::word_t inst,
    ctrlIf.dp             ctrl,
    output cpuPkg::word_t imm
);
    import cpuPkg::*;

    logic signBit;

    assign signBit = inst[31];

    always_comb begin
        case (ctrl.immSel)
            immS:    imm = {{(`XLEN-12){signBit}}, inst[31:25], inst[11:7]};
            // Byte offset with its low bit always zero
            immB:    imm = {{(`XLEN-13){signBit}}, inst[31], inst[7], inst[30:25],
                            inst[11:8], 1'b0};
            default: imm = {{(`XLEN-12){signBit}}, inst[31:20]};  // I format
        endcase
    end

endmodule

// File: instMem.sv
`include "cpu_macros.svh"

module instMem (
    input  logic          CLK,
    input  logic          we,
    input  logic [7:0]    wAddr,
    input  cpuPkg::word_t wData,
    input  cpuPkg::word_t pc,
    output cpuPkg::word_t inst
);
    import cpuPkg::*;

    localparam int AW = $clog2(`IMEM_DEPTH);

    word_t mem [0:`IMEM_DEPTH-1];

    // Load port used while the core is halted
    always_ff @(posedge CLK) begin
        if (we) begin
            mem[wAddr] <= wData;
        end
    end

    assign inst = mem[pc[AW+1:2]];  // Word index

endmodule

// File: pcUnit.sv
`include "cpu_macros.svh"

module pcUnit (
    input  logic          CLK,
    input  logic          rstN,
    input  logic          run,
    input  cpuPkg::word_t imm,
    input  logic          zero,
    ctrlIf.pc             ctrl,
    output cpuPkg::word_t pc
);
    import cpuPkg::*;

    logic  takeBranch;
    word_t nextPc;

    // BEQ on zero, BNE on nonzero
    assign takeBranch = (ctrl.branchEq && zero) || (ctrl.branchNe && !zero);
    assign nextPc     = takeBranch ? pc + imm : pc + 32'd4;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc <= `RESET_PC;
        end else if (run) begin
            pc <= nextPc;
        end
    end

    // Branch offsets from the immediate path must keep word alignment
    pcAligned: assert property (@(posedge CLK) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

// File: regFile.sv
`include "cpu_macros.svh"

module regFile (
    input  logic          CLK,
    input  logic          rstN,
    input  cpuPkg::word_t inst,
    ctrlIf.dp             ctrl,
    input  cpuPkg::word_t wData,
    output cpuPkg::word_t rs1Data,
    output cpuPkg::word_t rs2Data
);
    import cpuPkg::*;

    regIdx_t rs1Idx;
    regIdx_t rs2Idx;
    regIdx_t rdIdx;
    word_t   regs [0:`REG_COUNT-1];

    assign rs1Idx = inst[19:15];
    assign rs2Idx = inst[24:20];
    assign rdIdx  = inst[11:7];

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && rdIdx != '0) begin  // x0 is hardwired
            regs[rdIdx] <= wData;
        end
    end

    assign rs1Data = regs[rs1Idx];
    assign rs2Data = regs[rs2Idx];

    // x0 storage never picks up a value
    x0Zero: assert property (@(posedge CLK) disable iff (!rstN) regs[0] == '0)
        else $error("x0 holds %h", regs[0]);

endmodule

// File: singleCpu.sv
module singleCpu (
    input  logic            CLK,
    input  logic            rstN,
    input  logic            run,
    input  logic            imemWe,      // Program load port
    input  logic [7:0]      imemAddr,
    input  cpuPkg::word_t   imemData,
    output cpuPkg::word_t   pc,
    output logic            retireValid,
    output logic            retireWe,
    output cpuPkg::regIdx_t retireRd,
    output cpuPkg::word_t   retireData
);
    import cpuPkg::*;

    word_t inst;
    word_t rs1Data;
    word_t rs2Data;
    word_t imm;
    word_t aluResult;
    word_t loadData;
    word_t wbData;
    logic  zero;

    ctrlIf ctrlBus ();

    controlUnit ctrl0 (.run(run), .inst(inst), .ctrl(ctrlBus.ctrl));

    pcUnit pcU0 (.CLK(CLK), .rstN(rstN), .run(run), .imm(imm), .zero(zero),
                 .ctrl(ctrlBus.pc), .pc(pc));

    instMem imem0 (.CLK(CLK), .we(imemWe), .wAddr(imemAddr), .wData(imemData),
                   .pc(pc), .inst(inst));

    regFile regs0 (.CLK(CLK), .rstN(rstN), .inst(inst), .ctrl(ctrlBus.dp),
                   .wData(wbData), .rs1Data(rs1Data), .rs2Data(rs2Data));

    immGen imm0 (.inst(inst), .ctrl(ctrlBus.dp), .imm(imm));

    aluUnit alu0 (.rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm), .ctrl(ctrlBus.dp),
                  .aluResult(aluResult), .zero(zero));

    dataMem dmem0 (.CLK(CLK), .memWrite(ctrlBus.memWrite), .addr(aluResult),
                   .wData(rs2Data), .rData(loadData));

    // Writeback select
    assign wbData = ctrlBus.memToReg ? loadData : aluResult;

    // Retire report for the instruction at the current pc
    assign retireValid = run;
    assign retireRd    = inst[11:7];
    assign retireWe    = ctrlBus.regWrite && (retireRd != '0);  // x0 writes are dropped
    assign retireData  = wbData;

endmodule

// File: sources.f
+incdir+.
cpuPkg.sv
ctrlIf.sv
controlUnit.sv
pcUnit.sv
instMem.sv
regFile.sv
immGen.sv
aluUnit.sv
dataMem.sv
singleCpu.sv
tbSingleCpu.sv

// File: tbSingleCpu.sv
`include "cpu_macros.svh"

module tbSingleCpu;
    timeunit 1ns;
    timeprecision 100ps;
    import cpuPkg::*;

    // One program line
    typedef struct packed {
        opcode_e     op;
        aluOp_e      alu;
        logic        ne;     // BNE rather than BEQ
        regIdx_t     rd;
        regIdx_t     rs1;
        regIdx_t     rs2;
        logic [12:0] imm;    // Byte offset for branches
        logic        taken;  // Expected branch outcome
    } row_t;

    localparam int HALF_PERIOD  = 50;
    localparam int SETTLE       = 20;  // Sample point after the falling edge
    localparam int PAUSE_AT     = 10;  // Instruction count where run drops
    localparam int PAUSE_CYCLES = 5;

    logic    CLK;
    logic    rstN;
    logic    run;
    logic    imemWe;
    logic    [7:0] imemAddr;
    word_t   imemData;
    word_t   pc;
    logic    retireValid;
    logic    retireWe;
    regIdx_t retireRd;
    word_t   retireData;

    row_t        prog [$];
    word_t       regModel [0:`REG_COUNT-1];
    word_t       memModel [int];
    logic [31:0] lfsr = 32'h3dc18891;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycleLimit = 0;

    singleCpu dut0 (.CLK(CLK), .rstN(rstN), .run(run), .imemWe(imemWe),
                    .imemAddr(imemAddr), .imemData(imemData), .pc(pc),
                    .retireValid(retireValid), .retireWe(retireWe),
                    .retireRd(retireRd), .retireData(retireData));

    always #HALF_PERIOD CLK = ~CLK;

    // Watchdog
    always @(posedge CLK) begin
        cycles++;
        if (cycleLimit > 0 && cycles > cycleLimit) begin
            $display("Timeout: the program did not finish within %0d cycles", cycleLimit);
            $display("Regression failed");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [11:0] randImm12();
        logic [11:0] v;
        for (int i = 0; i < 12; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic word_t signExtend(logic [12:0] v);
        return {{(`XLEN-13){v[12]}}, v};
    endfunction

    function automatic word_t encode(row_t r);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = (r.alu == aluSub) ? 7'b0100000 : 7'b0000000;
        case (r.alu)
            aluAnd:  f3 = 3'b111;
            aluOr:   f3 = 3'b110;
            aluXor:  f3 = 3'b100;
            aluSlt:  f3 = 3'b010;
            default: f3 = 3'b000;  // ADD and SUB
        endcase
        case (r.op)
            opReg:    return {f7, r.rs2, r.rs1, f3, r.rd, r.op};
            opImm:    return {r.imm[11:0], r.rs1, 3'b000, r.rd, r.op};
            opLoad:   return {r.imm[11:0], r.rs1, 3'b010, r.rd, r.op};
            opStore:  return {r.imm[11:5], r.rs2, r.rs1, 3'b010, r.imm[4:0], r.op};
            opBranch: return {r.imm[12], r.imm[10:5], r.rs2, r.rs1, 2'b00, r.ne,
                              r.imm[4:1], r.imm[11], r.op};
            default:  return 32'h0;
        endcase
    endfunction

    task automatic appendRow(opcode_e op, aluOp_e alu, logic ne, regIdx_t rd, regIdx_t rs1,
                             regIdx_t rs2, logic [12:0] imm, logic taken);
        prog.push_back({op, alu, ne, rd, rs1, rs2, imm, taken});
    endtask

    task automatic randomAddi(regIdx_t rd, regIdx_t rs1);
        logic [11:0] v;
        v = randImm12();
        appendRow(opImm, aluAdd, 1'b0, rd, rs1, 5'd0, {v[11], v}, 1'b0);
    endtask

    task automatic buildProgram();
        randomAddi(5'd1, 5'd0);
        randomAddi(5'd2, 5'd1);
        randomAddi(5'd3, 5'd0);
        randomAddi(5'd4, 5'd3);
        appendRow(opReg, aluAdd, 1'b0, 5'd5, 5'd1, 5'd2, 13'd0, 1'b0);
        appendRow(opReg, aluSub, 1'b0, 5'd6, 5'd3, 5'd4, 13'd0, 1'b0);
        appendRow(opReg, aluAnd, 1'b0, 5'd7, 5'd5, 5'd6, 13'd0, 1'b0);
        appendRow(opReg, aluOr,  1'b0, 5'd8, 5'd1, 5'd3, 13'd0, 1'b0);
        appendRow(opReg, aluXor, 1'b0, 5'd9, 5'd2, 5'd4, 13'd0, 1'b0);
        appendRow(opReg, aluSlt, 1'b0, 5'd10, 5'd6, 5'd1, 13'd0, 1'b0);
        appendRow(opReg, aluSlt, 1'b0, 5'd11, 5'd1, 5'd6, 13'd0, 1'b0);
        randomAddi(5'd0, 5'd1);                                            // Lost in x0
        appendRow(opReg, aluAdd, 1'b0, 5'd12, 5'd0, 5'd2, 13'd0, 1'b0);
        appendRow(opImm, aluAdd, 1'b0, 5'd13, 5'd0, 5'd0, 13'd64, 1'b0);  // Base address
        appendRow(opStore, aluAdd, 1'b0, 5'd0, 5'd13, 5'd5, 13'd8, 1'b0);
        appendRow(opLoad, aluAdd, 1'b0, 5'd14, 5'd13, 5'd0, 13'd8, 1'b0);
        appendRow(opReg, aluAdd, 1'b0, 5'd15, 5'd14, 5'd0, 13'd0, 1'b0);
        appendRow(opBranch, aluSub, 1'b0, 5'd0, 5'd14, 5'd5, 13'd8, 1'b1);
        appendRow(opImm, aluAdd, 1'b0, 5'd16, 5'd0, 5'd0, 13'h7ff, 1'b0);  // Skipped
        appendRow(opBranch, aluSub, 1'b1, 5'd0, 5'd14, 5'd5, 13'd8, 1'b0);
        appendRow(opImm, aluAdd, 1'b0, 5'd17, 5'd0, 5'd0, 13'd5, 1'b0);
        appendRow(opBranch, aluSub, 1'b1, 5'd0, 5'd17, 5'd0, 13'd8, 1'b1);
        appendRow(opImm, aluAdd, 1'b0, 5'd18, 5'd0, 5'd0, 13'd1, 1'b0);    // Skipped
        appendRow(opBranch, aluSub, 1'b0, 5'd0, 5'd17, 5'd0, 13'd8, 1'b0);
        appendRow(opImm, aluAdd, 1'b0, 5'd19, 5'd17, 5'd0, 13'd3, 1'b0);
        appendRow(opStore, aluAdd, 1'b0, 5'd0, 5'd13, 5'd19, 13'h1ffc, 1'b0);  // -4
        appendRow(opLoad, aluAdd, 1'b0, 5'd20, 5'd13, 5'd0, 13'h1ffc, 1'b0);
    endtask

    task automatic checkWord(word_t got, word_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkReg(regIdx_t got, regIdx_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
        end
    endtask

    task automatic checkBit(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    initial begin
        row_t  r;
        word_t a;
        word_t b;
        word_t immW;
        word_t addr;
        word_t expData;
        word_t expNext;
        word_t mPc;
        word_t progEnd;
        logic  writes;
        logic  expWe;
        logic  taken;
        int    executed;

        CLK      = 1'b0;
        rstN     = 1'b0;
        run      = 1'b0;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        buildProgram();
        cycleLimit = 8 + 2 * prog.size() + 2 + PAUSE_CYCLES + 50;
        for (int i = 0; i < `REG_COUNT; i++) begin
            regModel[i] = '0;
        end

        repeat (8) @(negedge CLK);
        rstN = 1'b1;
        #SETTLE;
        checkWord(pc, `RESET_PC, "pc after reset");
        checkBit(retireWe, 1'b0, "retireWe after reset");
        checkBit(retireValid, 1'b0, "retireValid after reset");

        // Program load while halted
        foreach (prog[i]) begin
            @(negedge CLK);
            imemWe   = 1'b1;
            imemAddr = 8'(i);
            imemData = encode(prog[i]);
        end
        @(negedge CLK);
        imemAddr = 8'(prog.size());
        imemData = '0;  // Unknown opcode parks the core after the last row
        @(negedge CLK);
        imemWe = 1'b0;

        mPc      = `RESET_PC;
        progEnd  = prog.size() * 4;
        executed = 0;
        while (mPc < progEnd) begin
            r       = prog[mPc >> 2];
            a       = regModel[r.rs1];
            b       = regModel[r.rs2];
            immW    = signExtend(r.imm);
            addr    = a + immW;
            expData = '0;
            expNext = mPc + 4;
            writes  = 1'b0;
            case (r.op)
                opReg: begin
                    writes = 1'b1;
                    case (r.alu)
                        aluSub:  expData = a - b;
                        aluAnd:  expData = a & b;
                        aluOr:   expData = a | b;
                        aluXor:  expData = a ^ b;
                        aluSlt:  expData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: expData = a + b;
                    endcase
                end
                opImm: begin
                    writes  = 1'b1;
                    expData = addr;
                end
                opLoad: begin
                    writes = 1'b1;
                    if (memModel.exists(addr[9:2])) begin
                        expData = memModel[addr[9:2]];
                    end else begin
                        errors++;
                        $display("Program error: load from an address never stored");
                    end
                end
                opBranch: begin
                    taken = r.ne ? (a != b) : (a == b);
                    checkBit(taken, r.taken, "branch outcome in table");
                    if (r.taken) expNext = mPc + immW;
                end
                default: ;
            endcase
            expWe = writes && (r.rd != '0);

            @(negedge CLK);
            if (executed == PAUSE_AT) begin
                run = 1'b0;
                repeat (PAUSE_CYCLES) begin
                    #SETTLE;
                    checkBit(retireValid, 1'b0, "retireValid while halted");
                    checkBit(retireWe, 1'b0, "retireWe while halted");
                    checkWord(pc, mPc, "pc while halted");
                    if (writes) checkWord(retireData, expData, "retireData while halted");
                    @(negedge CLK);
                end
            end
            run = 1'b1;
            #SETTLE;
            checkWord(pc, mPc, "pc");
            checkBit(retireValid, 1'b1, "retireValid");
            checkBit(retireWe, expWe, "retireWe");
            if (writes) checkReg(retireRd, r.rd, "retireRd");
            if (expWe) checkWord(retireData, expData, "retireData");

            // Commit into the model
            if (expWe) regModel[r.rd] = expData;
            if (r.op == opStore) memModel[addr[9:2]] = b;
            mPc = expNext;
            executed++;
        end

        @(negedge CLK);
        run = 1'b0;
        #SETTLE;
        checkWord(pc, progEnd, "pc at end of program");
        checkBit(retireValid, 1'b0, "retireValid after run drops");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
